// File: all.f
+incdir+common
common/core_pkg.sv
hw/fetch/inst_fetch.sv
hw/fetch_buffer/fetch_buffer.sv
hw/decode/inst_decode.sv
hw/core_frontend.sv
verification/core_frontend_properties.sv
verification/core_frontend_tb.sv

// File: Bender.yml
package:
  name: core_frontend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - hw/fetch/inst_fetch.sv
      - hw/fetch_buffer/fetch_buffer.sv
      - hw/decode/inst_decode.sv
      - hw/core_frontend.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/core_frontend_properties.sv
      - verification/core_frontend_tb.sv

// File: verification/core_frontend_tb.sv
////////////////////////////////////////////////////////////
// core front end testbench
// icache model, reference decoder and directed tests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module core_frontend_tb;

  import core_pkg::*;

  localparam int TIMEOUT = 200;

  logic               clock;
  logic               rst_n;
  logic               icache_data_valid = 1'b0;
  logic [`XLEN-1:0]   icache_data = '0;
  logic               stall;
  logic               redirect;
  logic [`XLEN-1:0]   redirect_pc;
  logic               icache_req;
  logic [`XLEN-1:0]   icache_addr;
  micro_op_t          uop;
  logic               uop_valid;

  // 64 KiB instruction window, word indexed
  logic [31:0]        imem [16384];
  logic [`XLEN-1:0]   pc_queue [$];
  logic [`XLEN-1:0]   resp_addr;
  integer             seed = 78290;
  int                 resp_delay;
  int                 checks = 0;
  int                 errors = 0;

  core_frontend core_frontend_inst (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // icache model, answers 1 to 4 cycles after the request
  always @(posedge clock) begin
    icache_data_valid <= 1'b0;
    if (!rst_n) begin
      resp_delay = 0;
    end else begin
      if (icache_req) begin
        resp_addr  = icache_addr;
        resp_delay = 1 + ({$random(seed)} % 4);
      end
      if (resp_delay > 0) begin
        resp_delay = resp_delay - 1;
        if (resp_delay == 0) begin
          icache_data_valid <= 1'b1;
          icache_data       <= imem[resp_addr[15:2]];
        end
      end
    end
  end

  task automatic compare_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  // expected micro-op straight from the RV32I encoding
  task automatic reference_decode(input logic [31:0] pc, input logic [31:0] word,
                                  output micro_op_t exp);
    int         imm;
    uop_class_t cls;
    case (word[6:0])
      7'h13, 7'h03, 7'h67: imm = $signed(word[31:20]);
      7'h23: imm = $signed({word[31:25], word[11:7]});
      7'h63: imm = $signed({word[31], word[7], word[30:25], word[11:8], 1'b0});
      7'h37, 7'h17: imm = {word[31:12], 12'h000};
      7'h6f: imm = $signed({word[31], word[19:12], word[20], word[30:21], 1'b0});
      default: imm = 0;
    endcase
    case (word[6:0])
      7'h33, 7'h13, 7'h37, 7'h17: cls = UOP_ALU;
      7'h63: cls = UOP_BRANCH;
      7'h6f, 7'h67: cls = UOP_JUMP;
      7'h03: cls = UOP_LOAD;
      7'h23: cls = UOP_STORE;
      default: cls = UOP_ILLEGAL;
    endcase
    exp.pc        = pc;
    exp.uop_class = cls;
    exp.rd        = word[11:7];
    exp.rs1       = word[19:15];
    exp.rs2       = word[24:20];
    exp.funct3    = word[14:12];
    exp.imm       = imm;
    exp.writes_rd = (word[11:7] != 0) && (cls inside {UOP_ALU, UOP_JUMP, UOP_LOAD});
  endtask

  task automatic expect_pcs(input logic [31:0] start, input int count);
    for (int i = 0; i < count; i++) begin
      pc_queue.push_back(start + 32'(4 * i));
    end
  endtask

  // take count uops in order, checking each against the scoreboard
  task automatic collect_uops(input string test_name, input int count);
    micro_op_t   exp;
    logic [31:0] exp_pc;
    int          got;
    int          idle;
    got  = 0;
    idle = 0;
    while (got < count && idle < TIMEOUT) begin
      @(posedge clock);
      idle++;
      if (uop_valid === 1'b1) begin
        exp_pc = pc_queue.pop_front();
        reference_decode(exp_pc, imem[exp_pc[15:2]], exp);
        compare_value({test_name, " pc"}, exp.pc, uop.pc);
        compare_value({test_name, " class"}, exp.uop_class, uop.uop_class);
        compare_value({test_name, " rd"}, exp.rd, uop.rd);
        compare_value({test_name, " rs1"}, exp.rs1, uop.rs1);
        compare_value({test_name, " rs2"}, exp.rs2, uop.rs2);
        compare_value({test_name, " funct3"}, exp.funct3, uop.funct3);
        compare_value({test_name, " imm"}, exp.imm, uop.imm);
        compare_value({test_name, " writes_rd"}, exp.writes_rd, uop.writes_rd);
        got++;
        idle = 0;
      end
    end
    if (got < count) begin
      errors++;
      $display("%s timed out after %0d of %0d micro-ops", test_name, got, count);
    end
    pc_queue.delete();
  endtask

  task automatic redirect_to(input logic [31:0] target);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect    <= 1'b0;
  endtask

  task automatic wait_for_request(input string test_name, output logic [31:0] addr);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < TIMEOUT) begin
      @(posedge clock);
      waited++;
      seen = (icache_req === 1'b1);
      addr = icache_addr;
    end
    if (!seen) begin
      errors++;
      $display("%s saw no icache request within %0d cycles", test_name, TIMEOUT);
    end
  endtask

  task automatic reset_and_first_fetch();
    logic [31:0] addr;
    rst_n <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      if (i > 0) begin
        compare_value("reset icache_req", 0, icache_req);
        compare_value("reset uop_valid", 0, uop_valid);
      end
    end
    rst_n <= 1'b1;
    wait_for_request("first fetch", addr);
    compare_value("first fetch addr", `RESET_PC, addr);
  endtask

  task automatic decode_classes();
    logic [31:0] words [12];
    // add, addi -5, lui, auipc x0
    // jal -8, jalr x0, beq -16, bne +8
    // lw -4, lb x0, sw -16, sub x0
    words = '{32'h007302b3, 32'hffb10093, 32'hfffff1b7, 32'h12345017,
              32'hff9ff0ef, 32'h00c08067, 32'hfe4188e3, 32'h00629463,
              32'hffc12503, 32'h00048003, 32'hfeb62823, 32'h40208033};
    foreach (words[i]) begin
      imem[(32'h2000 >> 2) + i] = words[i];
    end
    expect_pcs(32'h2000, 12);
    redirect_to(32'h2000);
    collect_uops("decode classes", 12);
  endtask

  task automatic decode_illegal();
    imem[32'h3000 >> 2]         = 32'hffffffff;
    imem[(32'h3000 >> 2) + 1]   = 32'h000005ab;
    imem[(32'h3000 >> 2) + 2]   = 32'h00000000;
    expect_pcs(32'h3000, 3);
    redirect_to(32'h3000);
    collect_uops("illegal opcode", 3);
  endtask

  task automatic long_stall();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    stall <= 1'b1;
    expect_pcs(32'h4000, 20);
    redirect_to(32'h4000);
    // fetch goes quiet once the buffer is almost full
    while (quiet < 12 && waited < TIMEOUT) begin
      @(posedge clock);
      waited++;
      quiet = (icache_req === 1'b1) ? 0 : quiet + 1;
      compare_value("long stall uop_valid", 0, uop_valid);
    end
    if (quiet < 12) begin
      errors++;
      $display("long stall: fetch kept issuing requests for %0d cycles", TIMEOUT);
    end
    stall <= 1'b0;
    collect_uops("long stall", 20);
  endtask

  task automatic redirect_in_flight();
    logic [31:0] target;
    logic [31:0] addr;
    for (int k = 0; k < 3; k++) begin
      target = 32'h5000 + 32'(k) * 32'h1000;
      // old entries held in the buffer, so the redirect edge also pops one
      stall <= 1'b1;
      wait_for_request("redirect in flight", addr);
      wait_for_request("redirect in flight", addr);
      stall <= 1'b0;
      expect_pcs(target, 10);
      redirect_to(target);
      collect_uops("redirect in flight", 10);
    end
  endtask

  initial begin
    logic [31:0] fill_addr;
    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    // OP-IMM and LOAD words whose fields follow the address
    for (int i = 0; i < 16384; i++) begin
      fill_addr = 32'(i) << 2;
      imem[i] = {fill_addr[15:4], fill_addr[8:4], fill_addr[4:2], fill_addr[13:9],
                 fill_addr[2] ? 7'h03 : 7'h13};
    end
    reset_and_first_fetch();
    expect_pcs(`RESET_PC, 24);
    collect_uops("sequential", 24);
    decode_classes();
    decode_illegal();
    long_stall();
    redirect_in_flight();
    errors += core_frontend_inst.core_frontend_properties_inst.failures;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verification/core_frontend_properties.sv
////////////////////////////////////////////////////////////
// front-end protocol checks
// icache handshake, back-pressure and redirect behavior
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_frontend_properties (
  input logic clock,
  input logic rst_n,
  input logic icache_req,
  input logic icache_data_valid,
  input logic almost_full,
  input logic redirect,
  input logic uop_valid
);

  // request seen by the cache and not yet answered
  logic req_open;
  int   failures = 0;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      req_open <= 1'b0;
    end else if (icache_req) begin
      req_open <= 1'b1;
    end else if (icache_data_valid) begin
      req_open <= 1'b0;
    end
  end

  one_outstanding: assert property (
    @(posedge clock) disable iff (!rst_n) icache_req |-> !req_open
  ) else begin
    failures++;
    $error("icache request issued while another one is outstanding");
  end

  // almost_full gates the next issue edge
  no_req_when_full: assert property (
    @(posedge clock) disable iff (!rst_n) almost_full |=> !icache_req
  ) else begin
    failures++;
    $error("icache request issued with the fetch buffer almost full");
  end

  redirect_kills_uop: assert property (
    @(posedge clock) disable iff (!rst_n) redirect |=> !uop_valid
  ) else begin
    failures++;
    $error("uop_valid raised in the cycle after a redirect");
  end

endmodule

bind core_frontend core_frontend_properties core_frontend_properties_inst (
  .clock             (clock),
  .rst_n             (rst_n),
  .icache_req        (icache_req),
  .icache_data_valid (icache_data_valid),
  .almost_full       (almost_full),
  .redirect          (redirect),
  .uop_valid         (uop_valid)
);

// File: hw/core_frontend.sv
////////////////////////////////////////////////////////////
// core front end
// fetch, fetch buffer and decode between icache and back end
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module core_frontend (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                icache_data_valid,
  input  logic [`XLEN-1:0]    icache_data,
  input  logic                stall,
  input  logic                redirect,
  input  logic [`XLEN-1:0]    redirect_pc,
  output logic                icache_req,
  output logic [`XLEN-1:0]    icache_addr,
  output core_pkg::micro_op_t uop,
  output logic                uop_valid
);

  import core_pkg::*;

  logic      push;
  fb_entry_t push_entry;
  logic      almost_full;
  fb_entry_t head_entry;
  logic      not_empty;
  logic      pop;

  inst_fetch inst_fetch_inst (
    .clock             (clock),
    .rst_n             (rst_n),
    .icache_data_valid (icache_data_valid),
    .icache_data       (icache_data),
    .almost_full       (almost_full),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .icache_req        (icache_req),
    .icache_addr       (icache_addr),
    .push              (push),
    .push_entry        (push_entry)
  );

  // redirect empties the buffer
  fetch_buffer #(
    .entry_t (fb_entry_t),
    .DEPTH   (`FB_DEPTH)
  ) fetch_buffer_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .flush       (redirect),
    .push        (push),
    .push_entry  (push_entry),
    .pop         (pop),
    .head_entry  (head_entry),
    .not_empty   (not_empty),
    .almost_full (almost_full)
  );

  inst_decode inst_decode_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .flush      (redirect),
    .stall      (stall),
    .not_empty  (not_empty),
    .head_entry (head_entry),
    .pop        (pop),
    .uop        (uop),
    .uop_valid  (uop_valid)
  );

endmodule

// File: hw/decode/inst_decode.sv
////////////////////////////////////////////////////////////
// instruction decode
// RV32I fields and class into a registered micro-op
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module inst_decode (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                stall,
  input  logic                not_empty,
  input  core_pkg::fb_entry_t head_entry,
  output logic                pop,
  output core_pkg::micro_op_t uop,
  output logic                uop_valid
);

  import core_pkg::*;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  logic [`XLEN-1:0] inst;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  uop_class_t       dec_class;
  logic [`XLEN-1:0] dec_imm;
  logic             dec_writes_rd;

  assign pop  = not_empty && !stall;
  assign inst = head_entry.inst;

  // immediates, all formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (inst[6:0])
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: dec_class = UOP_ALU;
      OPC_JAL, OPC_JALR:                      dec_class = UOP_JUMP;
      OPC_BRANCH:                             dec_class = UOP_BRANCH;
      OPC_LOAD:                               dec_class = UOP_LOAD;
      OPC_STORE:                              dec_class = UOP_STORE;
      default:                                dec_class = UOP_ILLEGAL;
    endcase
  end

  // OP and unknown opcodes carry no immediate
  always_comb begin
    case (inst[6:0])
      OPC_OP_IMM, OPC_JALR, OPC_LOAD: dec_imm = imm_i;
      OPC_STORE:                      dec_imm = imm_s;
      OPC_BRANCH:                     dec_imm = imm_b;
      OPC_LUI, OPC_AUIPC:             dec_imm = imm_u;
      OPC_JAL:                        dec_imm = imm_j;
      default:                        dec_imm = '0;
    endcase
  end

  // x0 writes are dropped here
  assign dec_writes_rd = (inst[11:7] != 5'd0) &&
                         (dec_class == UOP_ALU || dec_class == UOP_JUMP ||
                          dec_class == UOP_LOAD);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= pop && !flush;
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      uop.pc        <= head_entry.pc;
      uop.uop_class <= dec_class;
      uop.rd        <= inst[11:7];
      uop.rs1       <= inst[19:15];
      uop.rs2       <= inst[24:20];
      uop.funct3    <= inst[14:12];
      uop.imm       <= dec_imm;
      uop.writes_rd <= dec_writes_rd;
    end
  end

endmodule

// File: hw/fetch_buffer/fetch_buffer.sv
////////////////////////////////////////////////////////////
// fetch buffer
// circular FIFO between fetch and decode, flushable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_buffer #(
  parameter type entry_t = core_pkg::fb_entry_t,
  parameter int  DEPTH   = `FB_DEPTH
) (
  input  logic   clock,
  input  logic   rst_n,
  input  logic   flush,
  input  logic   push,
  input  entry_t push_entry,
  input  logic   pop,
  output entry_t head_entry,
  output logic   not_empty,
  output logic   almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t             mem [DEPTH];
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   wr_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign not_empty   = (count != '0);
  // fewer than two free slots
  assign almost_full = (count > CNT_W'(DEPTH - 2));
  assign head_entry  = mem[rd_ptr];

  assign do_push = push && (count != CNT_W'(DEPTH));
  assign do_pop  = pop && not_empty;

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // simultaneous push and pop leave the count alone
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push && !flush) begin
      mem[wr_ptr] <= push_entry;
    end
  end

endmodule

// File: hw/fetch/inst_fetch.sv
////////////////////////////////////////////////////////////
// instruction fetch
// pc, single outstanding icache request, redirect handling
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_macros.svh"

module inst_fetch (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               icache_data_valid,
  input  logic [`XLEN-1:0]   icache_data,
  input  logic               almost_full,
  input  logic               redirect,
  input  logic [`XLEN-1:0]   redirect_pc,
  output logic               icache_req,
  output logic [`XLEN-1:0]   icache_addr,
  output logic               push,
  output core_pkg::fb_entry_t push_entry
);

  // address of the next request
  logic [`XLEN-1:0] fetch_pc;
  logic             outstanding;
  // outstanding response belongs to an abandoned path
  logic             stale;
  logic             resp;
  logic             can_issue;

  assign resp = icache_data_valid && outstanding;

  // a slot opens at the edge the response lands
  assign can_issue = (!outstanding || icache_data_valid) && !almost_full && !redirect;

  // icache_addr holds until the next issue, so it tags the response
  assign push       = resp && !stale && !redirect;
  assign push_entry = '{pc: icache_addr, inst: icache_data};

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      fetch_pc    <= `RESET_PC;
      outstanding <= 1'b0;
      stale       <= 1'b0;
      icache_req  <= 1'b0;
    end else begin
      icache_req <= can_issue;
      if (redirect) begin
        fetch_pc <= redirect_pc;
        // a request still in flight must be thrown away on return
        stale       <= outstanding && !icache_data_valid;
        outstanding <= outstanding && !icache_data_valid;
      end else begin
        if (can_issue) begin
          outstanding <= 1'b1;
          fetch_pc    <= fetch_pc + `XLEN'(4);
        end else if (resp) begin
          outstanding <= 1'b0;
        end
        if (resp) begin
          stale <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (can_issue) begin
      icache_addr <= fetch_pc;
    end
  end

endmodule

// File: common/core_pkg.sv
////////////////////////////////////////////////////////////
// front-end types
// fetch buffer entry and decoded micro-op record
////////////////////////////////////////////////////////////

`include "core_macros.svh"

package core_pkg;

  // one fetched instruction with its address
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
  } fb_entry_t;

  // coarse class for the back end
  typedef enum logic [2:0] {
    UOP_ALU     = 3'd0,
    UOP_BRANCH  = 3'd1,
    UOP_JUMP    = 3'd2,
    UOP_LOAD    = 3'd3,
    UOP_STORE   = 3'd4,
    UOP_ILLEGAL = 3'd5
  } uop_class_t;

  // decoded instruction
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    uop_class_t       uop_class;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [2:0]       funct3;
    // sign-extended per format
    logic [`XLEN-1:0] imm;
    logic             writes_rd;
  } micro_op_t;

endpackage

// File: common/core_macros.svh
////////////////////////////////////////////////////////////
// front-end build constants
// reset pc, fetch buffer depth and datapath width
////////////////////////////////////////////////////////////

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_1000
// fetch buffer entries
`define FB_DEPTH 8
// data and address width
`define XLEN 32

`endif
